// File: design/aluPkg.sv
/*
  Shared widths, instruction field positions, opcode and function codes
  and the payload types of the two-stage ALU pipeline.
  Every design and testbench file refers to it with aluPkg:: scoped names.
*/
package aluPkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int dataWidth     = 32;
    localparam int regIndexWidth = 5;
    // Holds 0 through 32
    localparam int countWidth    = 6;

    // ------------------------------
    // Instruction fields
    // ------------------------------
    localparam int opcodeLsb   = 26;
    localparam int rsLsb       = 21;
    localparam int rtLsb       = 16;
    localparam int rdLsb       = 11;
    localparam int shamtLsb    = 6;
    localparam int immWidth    = 16;
    localparam int opcodeWidth = 6;
    localparam int shamtWidth  = 5;
    // Function code sits in the low bits
    localparam int functWidth  = 6;

    // Major opcodes
    localparam logic [opcodeWidth-1:0] opSpecial  = 6'h00;
    localparam logic [opcodeWidth-1:0] opSpecial2 = 6'h1C;
    localparam logic [opcodeWidth-1:0] opAddi     = 6'h08;
    localparam logic [opcodeWidth-1:0] opAddiu    = 6'h09;

    // SPECIAL function codes
    localparam logic [functWidth-1:0] fnAdd  = 6'h20;
    localparam logic [functWidth-1:0] fnAddu = 6'h21;
    localparam logic [functWidth-1:0] fnSub  = 6'h22;
    localparam logic [functWidth-1:0] fnSubu = 6'h23;

    // SPECIAL2 function codes, bit 0 gives the counted polarity
    localparam logic [functWidth-1:0] fnClz = 6'h20;
    localparam logic [functWidth-1:0] fnClo = 6'h21;

    // ------------------------------
    // Types
    // ------------------------------
    typedef logic [dataWidth-1:0]     wordT;
    typedef logic [regIndexWidth-1:0] regIndexT;
    typedef logic [countWidth-1:0]    countT;

    // Operation class picked by the decoder
    typedef enum logic [2:0] {
        opNone,
        opAddTrap,
        opAddWrap,
        opSubTrap,
        opSubWrap,
        opClo,
        opClz
    } aluOpE;

    // Decoder output, operand B already holds the immediate when one is used
    typedef struct packed {
        aluOpE    op;
        wordT     operandA;
        wordT     operandB;
        regIndexT destReg;
    } decodedT;

    // One issued instruction with its register reads
    typedef struct packed {
        wordT instruction;
        wordT rsData;
        wordT rtData;
    } issueT;

    // Writeback record, 40 bits
    typedef struct packed {
        logic     writeEnable;
        regIndexT destReg;
        wordT     data;
        logic     overflow;
        logic     zero;
    } writebackT;

endpackage

// File: design/leadingCount.sv
/*
  Counts the leading bits of a word that equal the chosen polarity.
  Polarity 1 gives CLO, polarity 0 gives CLZ; a full match counts 32.
*/
module leadingCount (
    input  aluPkg::wordT  value,
    input  logic          polarity,
    output aluPkg::countT count
);

    // Drops low at the first bit that differs
    logic stillMatching;

    // Scan from the MSB down
    always_comb begin
        count         = '0;
        stillMatching = 1'b1;
        for (int bitIndex = aluPkg::dataWidth - 1; bitIndex >= 0; bitIndex--) begin
            stillMatching = stillMatching && (value[bitIndex] == polarity);
            count         = count + aluPkg::countT'(stillMatching);
        end
    end

endmodule

// File: design/instrDecode.sv
/*
  Combinational instruction decoder for the ALU slice.
  Picks the operation class, operand B and the destination register.
  Feeds the first pipeline stage.
*/
module instrDecode (
    input  aluPkg::issueT   issue,
    output aluPkg::decodedT decoded
);

    logic [aluPkg::opcodeWidth-1:0] opcode;
    logic [aluPkg::functWidth-1:0]  funct;
    logic [aluPkg::shamtWidth-1:0]  shamt;
    aluPkg::regIndexT               rtField;
    aluPkg::regIndexT               rdField;
    logic [aluPkg::immWidth-1:0]    immField;
    aluPkg::wordT                   immExtended;
    logic                           useImmediate;
    aluPkg::aluOpE                  opClass;

    // ------------------------------
    // Field extraction
    // ------------------------------
    assign opcode   = issue.instruction[aluPkg::opcodeLsb +: aluPkg::opcodeWidth];
    assign funct    = issue.instruction[aluPkg::functWidth-1:0];
    assign shamt    = issue.instruction[aluPkg::shamtLsb +: aluPkg::shamtWidth];
    assign rtField  = issue.instruction[aluPkg::rtLsb +: aluPkg::regIndexWidth];
    assign rdField  = issue.instruction[aluPkg::rdLsb +: aluPkg::regIndexWidth];
    assign immField = issue.instruction[aluPkg::immWidth-1:0];

    // Sign extension of the 16-bit immediate
    assign immExtended = {{(aluPkg::dataWidth - aluPkg::immWidth){immField[aluPkg::immWidth-1]}},
                          immField};

    // ------------------------------
    // Operation class
    // ------------------------------
    always_comb begin
        opClass      = aluPkg::opNone;
        useImmediate = 1'b0;
        case (opcode)
            aluPkg::opSpecial: begin
                // Nonzero shamt leaves the word unrecognized
                if (shamt == '0) begin
                    case (funct)
                        aluPkg::fnAdd:  opClass = aluPkg::opAddTrap;
                        aluPkg::fnAddu: opClass = aluPkg::opAddWrap;
                        aluPkg::fnSub:  opClass = aluPkg::opSubTrap;
                        aluPkg::fnSubu: opClass = aluPkg::opSubWrap;
                        default:        opClass = aluPkg::opNone;
                    endcase
                end
            end
            aluPkg::opSpecial2: begin
                if (shamt == '0) begin
                    case (funct)
                        aluPkg::fnClz: opClass = aluPkg::opClz;
                        aluPkg::fnClo: opClass = aluPkg::opClo;
                        default:       opClass = aluPkg::opNone;
                    endcase
                end
            end
            aluPkg::opAddi: begin
                opClass      = aluPkg::opAddTrap;
                useImmediate = 1'b1;
            end
            aluPkg::opAddiu: begin
                opClass      = aluPkg::opAddWrap;
                useImmediate = 1'b1;
            end
            default: opClass = aluPkg::opNone;
        endcase
    end

    // Immediate forms write rt, register forms write rd
    assign decoded = '{
        op:       opClass,
        operandA: issue.rsData,
        operandB: useImmediate ? immExtended : issue.rtData,
        destReg:  useImmediate ? rtField : rdField
    };

    // Every recognized class reads rs, so its value must be known
    always_comb begin
        if (!$isunknown(issue.instruction) && opClass != aluPkg::opNone) begin
            assert final (!$isunknown(issue.rsData))
            else $error("instrDecode: unknown rs value for class %0d", opClass);
        end
    end

endmodule

// File: design/pipeStage.sv
/*
  One-deep registered pipeline stage for a valid strobe and a payload.
  The payload type is set per instance; there is no back-pressure.
*/
module pipeStage #(
    parameter type payloadT = logic
) (
    input  logic    clock,
    input  logic    reset,
    input  logic    inValid,
    input  payloadT inPayload,
    output logic    outValid,
    output payloadT outPayload
);

    // Strobe register, cleared on reset
    always_ff @(posedge clock) begin
        if (reset) begin
            outValid <= 1'b0;
        end else begin
            outValid <= inValid;
        end
    end

    // Payload captured every cycle
    always_ff @(posedge clock) begin
        outPayload <= inPayload;
    end

    // Strobe must stay defined once out of reset
    assert property (@(posedge clock) disable iff (reset) !$isunknown(outValid))
    else $error("pipeStage: outValid unknown after reset");

endmodule

// File: design/aluExecute.sv
/*
  Combinational execute stage of the ALU slice.
  One shared adder serves add and subtract; leading counts go through
  leadingCount. Produces the writeback record for the output stage.
*/
module aluExecute (
    input  aluPkg::decodedT   decoded,
    output aluPkg::writebackT writeback
);

    logic          isSubtract;
    logic          isCountOnes;
    logic          signedOverflow;
    aluPkg::wordT  addendB;
    aluPkg::wordT  sum;
    aluPkg::countT leadCount;

    // ------------------------------
    // Shared add path
    // ------------------------------
    assign isSubtract = decoded.op inside {aluPkg::opSubTrap, aluPkg::opSubWrap};

    // Subtract as A + ~B + 1
    assign addendB = isSubtract ? ~decoded.operandB : decoded.operandB;
    assign sum     = decoded.operandA + addendB + aluPkg::wordT'(isSubtract);

    // Both addends share a sign and the sum sign flips
    assign signedOverflow = (decoded.operandA[aluPkg::dataWidth-1] ==
                             addendB[aluPkg::dataWidth-1]) &&
                            (sum[aluPkg::dataWidth-1] !=
                             decoded.operandA[aluPkg::dataWidth-1]);

    // ------------------------------
    // Leading count
    // ------------------------------
    assign isCountOnes = (decoded.op == aluPkg::opClo);

    leadingCount i_leadingCount (
        .value    (decoded.operandA),
        .polarity (isCountOnes),
        .count    (leadCount)
    );

    // ------------------------------
    // Writeback record
    // ------------------------------
    always_comb begin
        writeback.destReg = decoded.destReg;
        case (decoded.op)
            aluPkg::opAddTrap, aluPkg::opSubTrap: begin
                // Trap suppresses the register write
                writeback.writeEnable = !signedOverflow;
                writeback.data        = sum;
                writeback.overflow    = signedOverflow;
                writeback.zero        = (sum == '0);
            end
            aluPkg::opAddWrap, aluPkg::opSubWrap: begin
                writeback.writeEnable = 1'b1;
                writeback.data        = sum;
                writeback.overflow    = 1'b0;
                writeback.zero        = (sum == '0);
            end
            aluPkg::opClo, aluPkg::opClz: begin
                writeback.writeEnable = 1'b1;
                writeback.data        = aluPkg::wordT'(leadCount);
                writeback.overflow    = 1'b0;
                writeback.zero        = 1'b0;
            end
            default: begin
                // Unrecognized word, strobe only
                writeback.writeEnable = 1'b0;
                writeback.data        = '0;
                writeback.overflow    = 1'b0;
                writeback.zero        = 1'b0;
            end
        endcase
    end

    // The counter never reports more bits than a word holds
    always_comb begin
        if (!$isunknown(decoded.operandA)) begin
            assert final (leadCount <= aluPkg::countT'(aluPkg::dataWidth))
            else $error("aluExecute: leading count %0d above word width", leadCount);
        end
    end

endmodule

// File: design/aluPipe.sv
/*
  Top of the two-stage ALU pipeline.
  Decode, register, execute, register: a result strobes two cycles after issue.
*/
module aluPipe (
    input  logic              clock,
    input  logic              reset,
    input  logic              issueValid,
    input  aluPkg::issueT     issue,
    output logic              resultValid,
    output aluPkg::writebackT result
);

    aluPkg::decodedT   decodedIssue;
    logic              decodedValid;
    aluPkg::decodedT   decodedStaged;
    aluPkg::writebackT executeResult;

    // ------------------------------
    // Stage one
    // ------------------------------
    instrDecode i_instrDecode (
        .issue   (issue),
        .decoded (decodedIssue)
    );

    pipeStage #(
        .payloadT (aluPkg::decodedT)
    ) i_decodeStage (
        .clock      (clock),
        .reset      (reset),
        .inValid    (issueValid),
        .inPayload  (decodedIssue),
        .outValid   (decodedValid),
        .outPayload (decodedStaged)
    );

    // ------------------------------
    // Stage two
    // ------------------------------
    aluExecute i_aluExecute (
        .decoded   (decodedStaged),
        .writeback (executeResult)
    );

    pipeStage #(
        .payloadT (aluPkg::writebackT)
    ) i_writebackStage (
        .clock      (clock),
        .reset      (reset),
        .inValid    (decodedValid),
        .inPayload  (executeResult),
        .outValid   (resultValid),
        .outPayload (result)
    );

endmodule

// File: include/aluTbUtil.svh
/*
  Testbench helpers included into the ALU pipeline testbench module.
  LFSR stepping, instruction encoders, a reference model of the
  writeback record and compare tasks that stop the run on a mismatch.
*/
`ifndef ALU_TB_UTIL_SVH
`define ALU_TB_UTIL_SVH

localparam logic [31:0] lfsrSeed = 32'h78ce_6693;

// Fibonacci LFSR, taps 32 22 2 1, one step per bit
function automatic logic [31:0] lfsrAdvance(logic [31:0] state, int steps);
    logic [31:0] next;
    next = state;
    for (int step = 0; step < steps; step++) begin
        next = {next[30:0], next[31] ^ next[21] ^ next[1] ^ next[0]};
    end
    return next;
endfunction

// ------------------------------
// Instruction encoders
// ------------------------------
function automatic aluPkg::wordT encodeR(logic [5:0] opcode, aluPkg::regIndexT rs,
        aluPkg::regIndexT rt, aluPkg::regIndexT rd, logic [4:0] shamt, logic [5:0] funct);
    return (aluPkg::wordT'(opcode) << aluPkg::opcodeLsb) |
           (aluPkg::wordT'(rs) << aluPkg::rsLsb) | (aluPkg::wordT'(rt) << aluPkg::rtLsb) |
           (aluPkg::wordT'(rd) << aluPkg::rdLsb) |
           (aluPkg::wordT'(shamt) << aluPkg::shamtLsb) | aluPkg::wordT'(funct);
endfunction

function automatic aluPkg::wordT encodeI(logic [5:0] opcode, aluPkg::regIndexT rs,
        aluPkg::regIndexT rt, logic [15:0] imm);
    return (aluPkg::wordT'(opcode) << aluPkg::opcodeLsb) |
           (aluPkg::wordT'(rs) << aluPkg::rsLsb) |
           (aluPkg::wordT'(rt) << aluPkg::rtLsb) | aluPkg::wordT'(imm);
endfunction

// Expected writeback record, worked out with wide signed arithmetic
function automatic aluPkg::writebackT modelWriteback(aluPkg::issueT issue);
    aluPkg::writebackT wb;
    logic [5:0]        opcode;
    logic [5:0]        funct;
    logic              shamtZero;
    logic              subtract;
    logic              trap;
    aluPkg::wordT      operandB;
    longint            exact;
    opcode    = issue.instruction[31:26];
    funct     = issue.instruction[5:0];
    shamtZero = (issue.instruction[10:6] == 5'd0);
    operandB  = issue.rtData;
    subtract  = 1'b0;
    trap      = 1'b0;
    wb        = '0;
    wb.destReg = issue.instruction[15:11];
    if (opcode == aluPkg::opSpecial2 && shamtZero &&
        funct inside {aluPkg::fnClz, aluPkg::fnClo}) begin
        // Count bits equal to funct[0] until the first mismatch
        wb.writeEnable = 1'b1;
        for (int bitIndex = 31; bitIndex >= 0; bitIndex--) begin
            if (issue.rsData[bitIndex] != funct[0]) begin
                break;
            end
            wb.data = wb.data + 1;
        end
        return wb;
    end else if (opcode == aluPkg::opSpecial && shamtZero &&
                 funct inside {aluPkg::fnAdd, aluPkg::fnAddu, aluPkg::fnSub, aluPkg::fnSubu}) begin
        subtract = funct[1];
        trap     = !funct[0];
    end else if (opcode == aluPkg::opAddi || opcode == aluPkg::opAddiu) begin
        operandB   = {{16{issue.instruction[15]}}, issue.instruction[15:0]};
        wb.destReg = issue.instruction[20:16];
        trap       = (opcode == aluPkg::opAddi);
    end else begin
        return wb;
    end
    exact = subtract ? longint'($signed(issue.rsData)) - longint'($signed(operandB))
                     : longint'($signed(issue.rsData)) + longint'($signed(operandB));
    wb.data        = exact[31:0];
    wb.zero        = (wb.data == '0);
    wb.overflow    = trap && (exact != longint'($signed(wb.data)));
    wb.writeEnable = !wb.overflow;
    return wb;
endfunction

// ------------------------------
// Compare tasks
// ------------------------------
task automatic compareWriteback(string name, aluPkg::writebackT actual,
        aluPkg::writebackT expected);
    if (actual !== expected) begin
        $display("Mismatch %s: actual 0x%h expected 0x%h", name, actual, expected);
        $display("*** FAILED ***");
        $fatal(1);
    end
endtask

task automatic compareValid(string name, bit actual, bit expected);
    if (actual !== expected) begin
        $display("Mismatch %s: actual 0x%h expected 0x%h", name, actual, expected);
        $display("*** FAILED ***");
        $fatal(1);
    end
endtask

`endif

// File: dv/aluPipeTb.sv
/*
  Directed testbench for the two-stage ALU pipeline.
  Each test task issues instructions and queues the modelled writeback;
  a monitor checks every result strobe for value, order and latency.
*/
module aluPipeTb;

    timeunit 1ns;
    timeprecision 100ps;

    `include "aluTbUtil.svh"

    // ------------------------------
    // Run length
    // ------------------------------
    localparam int clockPeriod  = 4;
    localparam int randomPairs  = 12;
    localparam int burstLength  = 40;
    localparam int testCount    = 5;
    // Idle cycle plus three wait cycles after each test
    localparam int drainCycles  = 4;
    localparam int totalIssues  = (3 * randomPairs + 1) + (7 + 3 * randomPairs) +
                                  (4 + 64 + 2 * randomPairs) + 5 + burstLength;
    localparam int watchdogCycles = totalIssues + testCount * drainCycles + 2 + 3 + 4 + 64;

    logic              clock = 1'b0;
    logic              reset;
    logic              issueValid;
    aluPkg::issueT     issue;
    logic              resultValid;
    aluPkg::writebackT result;

    // Expected results and the edge at which each issue was sampled
    aluPkg::writebackT expectedQueue[$];
    int                issueEdges[$];
    int                cycleCount = 0;
    logic [31:0]       lfsrState = lfsrSeed;

    aluPipe i_aluPipe (
        .clock       (clock),
        .reset       (reset),
        .issueValid  (issueValid),
        .issue       (issue),
        .resultValid (resultValid),
        .result      (result)
    );

    always #(clockPeriod / 2) clock = ~clock;

    // Edge counter, read as its old value at each edge
    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
    end

    // ------------------------------
    // Random fields
    // ------------------------------
    function automatic aluPkg::wordT randomWord();
        lfsrState = lfsrAdvance(lfsrState, 32);
        return lfsrState;
    endfunction

    function automatic aluPkg::regIndexT randomReg();
        lfsrState = lfsrAdvance(lfsrState, 5);
        return lfsrState[4:0];
    endfunction

    function automatic logic [15:0] randomImm();
        lfsrState = lfsrAdvance(lfsrState, 16);
        return lfsrState[15:0];
    endfunction

    function automatic logic [2:0] randomKind();
        lfsrState = lfsrAdvance(lfsrState, 3);
        return lfsrState[2:0];
    endfunction

    // Small signed value, sums and differences of two never overflow
    function automatic aluPkg::wordT randomSmall();
        return aluPkg::wordT'($signed(randomWord()) >>> 2);
    endfunction

    // ------------------------------
    // Drive helpers
    // ------------------------------
    task automatic issueInstr(aluPkg::wordT instruction, aluPkg::wordT rsData,
            aluPkg::wordT rtData);
        aluPkg::issueT item;
        item = '{instruction: instruction, rsData: rsData, rtData: rtData};
        @(posedge clock);
        issueValid <= 1'b1;
        issue      <= item;
        expectedQueue.push_back(modelWriteback(item));
        // DUT samples it at the next edge
        issueEdges.push_back(cycleCount + 1);
    endtask

    task automatic idleCycle();
        @(posedge clock);
        issueValid <= 1'b0;
    endtask

    // All results must be out two edges after the last issue
    task automatic drainTest(string testName);
        idleCycle();
        repeat (3) @(posedge clock);
        if (expectedQueue.size() != 0) begin
            $display("%s: %0d results never arrived", testName, expectedQueue.size());
            $display("*** FAILED ***");
            $fatal(1);
        end
        $display("%s done", testName);
    endtask

    // ------------------------------
    // Result monitor
    // ------------------------------
    always @(posedge clock) begin : resultMonitor
        bit expectNow;
        if (!reset) begin
            if (resultValid === 1'b1 && expectedQueue.size() == 0) begin
                $display("resultValid strobed with no instruction outstanding");
                $display("*** FAILED ***");
                $fatal(1);
            end
            // Front entry is due exactly two edges after its issue
            expectNow = (expectedQueue.size() > 0) && (issueEdges[0] + 2 == cycleCount);
            compareValid("resultValid", resultValid, expectNow);
            if (expectNow) begin
                compareWriteback("result", result, expectedQueue.pop_front());
                void'(issueEdges.pop_front());
            end
        end
    end

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic checkQuietAfterReset();
        repeat (3) begin
            @(posedge clock);
            compareValid("resultValid", resultValid, 1'b0);
        end
    endtask

    task automatic testWrapping();
        aluPkg::wordT operand;
        for (int pass = 0; pass < randomPairs; pass++) begin
            issueInstr(encodeR(aluPkg::opSpecial, randomReg(), randomReg(), randomReg(), 5'd0,
                aluPkg::fnAddu), randomWord(), randomWord());
            issueInstr(encodeR(aluPkg::opSpecial, randomReg(), randomReg(), randomReg(), 5'd0,
                aluPkg::fnSubu), randomWord(), randomWord());
            // Negative immediate
            issueInstr(encodeI(aluPkg::opAddiu, randomReg(), randomReg(),
                randomImm() | 16'h8000), randomWord(), randomWord());
        end
        // Equal operands give zero
        operand = randomWord();
        issueInstr(encodeR(aluPkg::opSpecial, 5'd4, 5'd5, 5'd6, 5'd0, aluPkg::fnSubu),
            operand, operand);
        drainTest("wrapping");
    endtask

    task automatic testTrapping();
        aluPkg::wordT addWord;
        aluPkg::wordT subWord;
        addWord = encodeR(aluPkg::opSpecial, 5'd1, 5'd2, 5'd3, 5'd0, aluPkg::fnAdd);
        subWord = encodeR(aluPkg::opSpecial, 5'd1, 5'd2, 5'd3, 5'd0, aluPkg::fnSub);
        // Positive and negative overflow for each trapping form
        issueInstr(addWord, 32'h7fff_ffff, 32'h0000_0001);
        issueInstr(addWord, 32'h8000_0000, 32'hffff_ffff);
        issueInstr(addWord, 32'h8000_0000, 32'h8000_0000);
        issueInstr(subWord, 32'h7fff_ffff, 32'hffff_ffff);
        issueInstr(subWord, 32'h8000_0000, 32'h0000_0001);
        issueInstr(encodeI(aluPkg::opAddi, 5'd7, 5'd8, 16'h0001), 32'h7fff_ffff, randomWord());
        issueInstr(encodeI(aluPkg::opAddi, 5'd7, 5'd9, 16'hffff), 32'h8000_0000, randomWord());
        for (int pass = 0; pass < randomPairs; pass++) begin
            issueInstr(encodeR(aluPkg::opSpecial, randomReg(), randomReg(), randomReg(), 5'd0,
                aluPkg::fnAdd), randomSmall(), randomSmall());
            issueInstr(encodeR(aluPkg::opSpecial, randomReg(), randomReg(), randomReg(), 5'd0,
                aluPkg::fnSub), randomSmall(), randomSmall());
            issueInstr(encodeI(aluPkg::opAddi, randomReg(), randomReg(), randomImm()),
                randomSmall(), randomWord());
        end
        drainTest("trapping");
    endtask

    task automatic testLeadingCounts();
        aluPkg::wordT cloWord;
        aluPkg::wordT clzWord;
        aluPkg::wordT singleBit;
        cloWord = encodeR(aluPkg::opSpecial2, 5'd10, 5'd0, 5'd11, 5'd0, aluPkg::fnClo);
        clzWord = encodeR(aluPkg::opSpecial2, 5'd10, 5'd0, 5'd12, 5'd0, aluPkg::fnClz);
        // Extremes, 0 and 32
        issueInstr(cloWord, 32'h0000_0000, randomWord());
        issueInstr(cloWord, 32'hffff_ffff, randomWord());
        issueInstr(clzWord, 32'h0000_0000, randomWord());
        issueInstr(clzWord, 32'hffff_ffff, randomWord());
        for (int bitIndex = 0; bitIndex < 32; bitIndex++) begin
            singleBit = aluPkg::wordT'(1) << bitIndex;
            issueInstr(clzWord, singleBit, randomWord());
            issueInstr(cloWord, ~singleBit, randomWord());
        end
        for (int pass = 0; pass < randomPairs; pass++) begin
            issueInstr(cloWord, randomWord(), randomWord());
            issueInstr(clzWord, randomWord(), randomWord());
        end
        drainTest("leading counts");
    endtask

    task automatic testUnrecognized();
        issueInstr('0, randomWord(), randomWord());
        idleCycle();
        // AND is outside this slice
        issueInstr(encodeR(aluPkg::opSpecial, 5'd1, 5'd2, 5'd3, 5'd0, 6'h24),
            randomWord(), randomWord());
        idleCycle();
        issueInstr(encodeR(aluPkg::opSpecial, 5'd1, 5'd2, 5'd3, 5'd3, aluPkg::fnAdd),
            randomWord(), randomWord());
        idleCycle();
        issueInstr(encodeR(aluPkg::opSpecial2, 5'd1, 5'd2, 5'd3, 5'd1, aluPkg::fnClo),
            randomWord(), randomWord());
        idleCycle();
        // ANDI opcode
        issueInstr(encodeI(6'h0C, 5'd1, 5'd2, randomImm()), randomWord(), randomWord());
        drainTest("unrecognized");
    endtask

    task automatic testBurst();
        aluPkg::wordT instruction;
        for (int pass = 0; pass < burstLength; pass++) begin
            case (randomKind())
                3'd0: instruction = encodeR(aluPkg::opSpecial, randomReg(), randomReg(),
                    randomReg(), 5'd0, aluPkg::fnAdd);
                3'd1: instruction = encodeR(aluPkg::opSpecial, randomReg(), randomReg(),
                    randomReg(), 5'd0, aluPkg::fnAddu);
                3'd2: instruction = encodeR(aluPkg::opSpecial, randomReg(), randomReg(),
                    randomReg(), 5'd0, aluPkg::fnSub);
                3'd3: instruction = encodeR(aluPkg::opSpecial, randomReg(), randomReg(),
                    randomReg(), 5'd0, aluPkg::fnSubu);
                3'd4: instruction = encodeI(aluPkg::opAddi, randomReg(), randomReg(),
                    randomImm());
                3'd5: instruction = encodeI(aluPkg::opAddiu, randomReg(), randomReg(),
                    randomImm());
                3'd6: instruction = encodeR(aluPkg::opSpecial2, randomReg(), randomReg(),
                    randomReg(), 5'd0, aluPkg::fnClo);
                default: instruction = encodeR(aluPkg::opSpecial2, randomReg(), randomReg(),
                    randomReg(), 5'd0, aluPkg::fnClz);
            endcase
            issueInstr(instruction, randomWord(), randomWord());
        end
        drainTest("burst");
    endtask

    // ------------------------------
    // Watchdog and main sequence
    // ------------------------------
    initial begin
        #(watchdogCycles * clockPeriod);
        $display("Watchdog expired before the tests finished");
        $display("*** FAILED ***");
        $fatal(1);
    end

    initial begin
        reset      = 1'b1;
        issueValid = 1'b0;
        issue      = '0;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        checkQuietAfterReset();
        testWrapping();
        testTrapping();
        testLeadingCounts();
        testUnrecognized();
        testBurst();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: compile.f
+incdir+include
design/aluPkg.sv
design/leadingCount.sv
design/instrDecode.sv
design/pipeStage.sv
design/aluExecute.sv
design/aluPipe.sv
dv/aluPipeTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := aluPipeTb
FILELIST  := compile.f

BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) include/aluTbUtil.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
